// File: core_pkg.sv
/*
 * Core package
 * Widths, RV32I subset encodings, ALU operations and the
 * instruction word with its register and branch views
 */
package core_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // Major opcodes of the supported subset
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_branch = 7'b1100011;

    // funct3 encodings
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;
    localparam logic [2:0] f3_beq     = 3'b000;
    localparam logic [2:0] f3_bne     = 3'b001;

    // funct7 that turns ADD into SUB
    localparam logic [6:0] f7_sub = 7'b0100000;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_pass_b
    } alu_op_t;

    // Register layout, its upper fields also carry the I and U immediates
    typedef struct packed {
        logic [6:0]            funct7;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } r_type_t;

    // Branch layout with the scattered offset bits
    typedef struct packed {
        logic                  imm_12;
        logic [5:0]            imm_10_5;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm_4_1;
        logic                  imm_11;
        logic [6:0]            opcode;
    } b_type_t;

    typedef union packed {
        r_type_t r;
        b_type_t b;
    } instr_t;

endpackage

// File: fetch_stage.sv
/*
 * Fetch stage
 * Program counter with branch redirect and hold, drives the
 * instruction memory request and the fetched slot
 */
module fetch_stage #(
    parameter logic [core_pkg::xlen-1:0] reset_addr = '0
) (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  logic                      hold_i,
    input  logic                      redirect_i,
    input  logic [core_pkg::xlen-1:0] target_i,
    output logic [core_pkg::xlen-1:0] imem_addr_o,
    output logic                      imem_req_o,
    output logic [core_pkg::xlen-1:0] pc_o,
    output logic                      valid_o
);

    logic [core_pkg::xlen-1:0] pc_q;
    logic                      req_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q  <= reset_addr;
            req_q <= 1'b0;
        end else begin
            // No request during the first cycle out of reset
            req_q <= 1'b1;
            if (redirect_i) begin
                pc_q <= target_i;
            end else if (!hold_i) begin
                pc_q <= pc_q + core_pkg::xlen'(4);
            end
        end
    end

    assign imem_addr_o = pc_q;
    assign imem_req_o  = req_q;
    assign pc_o        = pc_q;

    // Slot is dropped when memory is late or a branch redirects
    assign valid_o = req_q && !hold_i && !redirect_i;

endmodule

// File: decoder.sv
/*
 * Instruction decoder
 * Register addresses, immediate, ALU operation and control bits
 * for the RV32I subset, unsupported words decode to a bubble
 */
module decoder (
    input  core_pkg::instr_t                instr_i,
    input  logic                            valid_i,
    output logic [core_pkg::reg_addr_w-1:0] rs1_o,
    output logic [core_pkg::reg_addr_w-1:0] rs2_o,
    output logic [core_pkg::reg_addr_w-1:0] rd_o,
    output logic [core_pkg::xlen-1:0]       imm_o,
    output core_pkg::alu_op_t               alu_op_o,
    output logic                            use_imm_o,
    output logic                            we_o,
    output logic                            is_branch_o,
    output logic                            branch_ne_o,
    output logic                            valid_o
);

    logic [core_pkg::xlen-1:0] imm_i_type;
    logic [core_pkg::xlen-1:0] imm_u_type;
    logic [core_pkg::xlen-1:0] imm_b_type;
    logic                      legal;

    // I and U immediates come from the register view
    assign imm_i_type = {{20{instr_i.r.funct7[6]}}, instr_i.r.funct7, instr_i.r.rs2};
    assign imm_u_type = {instr_i.r.funct7, instr_i.r.rs2, instr_i.r.rs1,
                         instr_i.r.funct3, 12'b0};
    // Branch offset from the branch view
    assign imm_b_type = {{19{instr_i.b.imm_12}}, instr_i.b.imm_12, instr_i.b.imm_11,
                         instr_i.b.imm_10_5, instr_i.b.imm_4_1, 1'b0};

    assign rs1_o = instr_i.r.rs1;
    assign rs2_o = instr_i.r.rs2;
    assign rd_o  = instr_i.r.rd;

    always_comb begin
        imm_o       = '0;
        alu_op_o    = core_pkg::alu_add;
        use_imm_o   = 1'b0;
        we_o        = 1'b0;
        is_branch_o = 1'b0;
        branch_ne_o = 1'b0;
        legal       = 1'b0;
        case (instr_i.r.opcode)
            core_pkg::op_reg: begin
                we_o = 1'b1;
                legal = (instr_i.r.funct7 == 7'b0);
                case (instr_i.r.funct3)
                    core_pkg::f3_add_sub: begin
                        if (instr_i.r.funct7 == core_pkg::f7_sub) begin
                            alu_op_o = core_pkg::alu_sub;
                            legal    = 1'b1;
                        end
                    end
                    core_pkg::f3_xor: alu_op_o = core_pkg::alu_xor;
                    core_pkg::f3_or:  alu_op_o = core_pkg::alu_or;
                    core_pkg::f3_and: alu_op_o = core_pkg::alu_and;
                    default:          legal = 1'b0;
                endcase
            end
            core_pkg::op_imm: begin
                imm_o     = imm_i_type;
                use_imm_o = 1'b1;
                we_o      = 1'b1;
                legal     = 1'b1;
                case (instr_i.r.funct3)
                    core_pkg::f3_add_sub: alu_op_o = core_pkg::alu_add;
                    core_pkg::f3_xor:     alu_op_o = core_pkg::alu_xor;
                    core_pkg::f3_or:      alu_op_o = core_pkg::alu_or;
                    core_pkg::f3_and:     alu_op_o = core_pkg::alu_and;
                    default:              legal = 1'b0;
                endcase
            end
            core_pkg::op_lui: begin
                imm_o     = imm_u_type;
                alu_op_o  = core_pkg::alu_pass_b;
                use_imm_o = 1'b1;
                we_o      = 1'b1;
                legal     = 1'b1;
            end
            core_pkg::op_branch: begin
                imm_o       = imm_b_type;
                is_branch_o = 1'b1;
                branch_ne_o = (instr_i.b.funct3 == core_pkg::f3_bne);
                legal       = (instr_i.b.funct3 == core_pkg::f3_beq) ||
                              (instr_i.b.funct3 == core_pkg::f3_bne);
            end
            default: legal = 1'b0;
        endcase
        valid_o = valid_i && legal;
    end

endmodule

// File: regfile.sv
/*
 * Integer register file
 * 31 registers plus a hardwired x0, writes pass through to reads
 */
module regfile (
    input  logic                            clk_i,
    input  logic                            rstn_i,
    input  logic                            we_i,
    input  logic [core_pkg::reg_addr_w-1:0] waddr_i,
    input  logic [core_pkg::xlen-1:0]       wdata_i,
    input  logic [core_pkg::reg_addr_w-1:0] raddr1_i,
    input  logic [core_pkg::reg_addr_w-1:0] raddr2_i,
    output logic [core_pkg::xlen-1:0]       rdata1_o,
    output logic [core_pkg::xlen-1:0]       rdata2_o
);

    logic [core_pkg::xlen-1:0] regs_q [1:31];
    logic                      wr_en;

    assign wr_en = we_i && (waddr_i != '0);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // x0 first, then the write in flight, then the stored value
    assign rdata1_o = (raddr1_i == '0) ? '0 :
                      (wr_en && waddr_i == raddr1_i) ? wdata_i : regs_q[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 :
                      (wr_en && waddr_i == raddr2_i) ? wdata_i : regs_q[raddr2_i];

endmodule

// File: exe_stage.sv
/*
 * Execute stage
 * Writeback forwarding, ALU and branch resolution with target
 */
module exe_stage (
    input  logic [core_pkg::xlen-1:0]       pc_i,
    input  logic                            valid_i,
    input  logic [core_pkg::reg_addr_w-1:0] rs1_i,
    input  logic [core_pkg::reg_addr_w-1:0] rs2_i,
    input  logic [core_pkg::xlen-1:0]       op_a_i,
    input  logic [core_pkg::xlen-1:0]       op_b_i,
    input  logic [core_pkg::xlen-1:0]       imm_i,
    input  core_pkg::alu_op_t               alu_op_i,
    input  logic                            use_imm_i,
    input  logic                            is_branch_i,
    input  logic                            branch_ne_i,
    input  logic                            wb_we_i,
    input  logic [core_pkg::reg_addr_w-1:0] wb_rd_i,
    input  logic [core_pkg::xlen-1:0]       wb_data_i,
    output logic [core_pkg::xlen-1:0]       result_o,
    output logic                            branch_taken_o,
    output logic [core_pkg::xlen-1:0]       target_o
);

    logic [core_pkg::xlen-1:0] fwd_a;
    logic [core_pkg::xlen-1:0] fwd_b;
    logic [core_pkg::xlen-1:0] alu_b;
    logic                      wb_hit;
    logic                      equal;

    // Writeback result overrides a stale register read
    assign wb_hit = wb_we_i && (wb_rd_i != '0);
    assign fwd_a  = (wb_hit && wb_rd_i == rs1_i) ? wb_data_i : op_a_i;
    assign fwd_b  = (wb_hit && wb_rd_i == rs2_i) ? wb_data_i : op_b_i;

    assign alu_b = use_imm_i ? imm_i : fwd_b;

    always_comb begin
        case (alu_op_i)
            core_pkg::alu_add:    result_o = fwd_a + alu_b;
            core_pkg::alu_sub:    result_o = fwd_a - alu_b;
            core_pkg::alu_and:    result_o = fwd_a & alu_b;
            core_pkg::alu_or:     result_o = fwd_a | alu_b;
            core_pkg::alu_xor:    result_o = fwd_a ^ alu_b;
            core_pkg::alu_pass_b: result_o = alu_b;
            default:              result_o = '0;
        endcase
    end

    // BEQ and BNE compare the register operands, never the immediate
    assign equal          = (fwd_a == fwd_b);
    assign branch_taken_o = valid_i && is_branch_i && (branch_ne_i ? !equal : equal);
    assign target_o       = pc_i + imm_i;

endmodule

// File: control_unit.sv
/*
 * Pipeline control
 * Fetch hold on a late instruction and flush on a taken branch
 */
module control_unit (
    input  logic clk_i,
    input  logic rstn_i,
    input  logic imem_valid_i,
    input  logic branch_taken_i,
    output logic hold_fetch_o,
    output logic flush_o
);

    logic started_q;

    // Low for the first cycle out of reset
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            started_q <= 1'b0;
        end else begin
            started_q <= 1'b1;
        end
    end

    // Redirect wins over a memory hold
    assign hold_fetch_o = !branch_taken_i && (!started_q || !imem_valid_i);

    // Kills IF/ID, ID/RR and RR/EXE
    assign flush_o = branch_taken_i;

endmodule

// File: datapath.sv
/*
 * RV32I core top level
 * Five stages if, id, rr, exe and wb with their pipeline registers,
 * writeback selection and the commit port
 */
module datapath #(
    parameter logic [core_pkg::xlen-1:0] reset_addr = '0
) (
    input  logic                            clk_i,
    input  logic                            rstn_i,
    output logic [core_pkg::xlen-1:0]       imem_addr_o,
    output logic                            imem_req_o,
    input  logic [core_pkg::xlen-1:0]       imem_data_i,
    input  logic                            imem_valid_i,
    output logic                            commit_valid_o,
    output logic [core_pkg::xlen-1:0]       commit_pc_o,
    output logic                            commit_we_o,
    output logic [core_pkg::reg_addr_w-1:0] commit_rd_o,
    output logic [core_pkg::xlen-1:0]       commit_data_o
);

    logic                            hold_fetch;
    logic                            flush;
    logic                            branch_taken;
    logic [core_pkg::xlen-1:0]       branch_target;
    logic [core_pkg::xlen-1:0]       f_pc;
    logic                            f_valid;

    // IF/ID
    logic [core_pkg::xlen-1:0]       if_pc_q;
    core_pkg::instr_t                if_instr_q;
    logic                            if_valid_q;

    // Decode outputs
    logic [core_pkg::reg_addr_w-1:0] dec_rs1, dec_rs2, dec_rd;
    logic [core_pkg::xlen-1:0]       dec_imm;
    core_pkg::alu_op_t               dec_alu_op;
    logic                            dec_use_imm, dec_we, dec_is_branch;
    logic                            dec_branch_ne, dec_valid;

    // ID/RR
    logic [core_pkg::xlen-1:0]       id_pc_q, id_imm_q;
    logic [core_pkg::reg_addr_w-1:0] id_rs1_q, id_rs2_q, id_rd_q;
    core_pkg::alu_op_t               id_alu_op_q;
    logic                            id_use_imm_q, id_we_q, id_is_branch_q;
    logic                            id_branch_ne_q, id_valid_q;
    logic [core_pkg::xlen-1:0]       rf_rdata1, rf_rdata2;

    // RR/EXE
    logic [core_pkg::xlen-1:0]       rr_pc_q, rr_imm_q, rr_op_a_q, rr_op_b_q;
    logic [core_pkg::reg_addr_w-1:0] rr_rs1_q, rr_rs2_q, rr_rd_q;
    core_pkg::alu_op_t               rr_alu_op_q;
    logic                            rr_use_imm_q, rr_we_q, rr_is_branch_q;
    logic                            rr_branch_ne_q, rr_valid_q;
    logic [core_pkg::xlen-1:0]       exe_result;

    // EXE/WB
    logic [core_pkg::xlen-1:0]       wb_pc_q, wb_result_q;
    logic [core_pkg::reg_addr_w-1:0] wb_rd_q;
    logic                            wb_we_q, wb_valid_q;
    logic                            wb_write;

    control_unit control_unit_i (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .imem_valid_i   (imem_valid_i),
        .branch_taken_i (branch_taken),
        .hold_fetch_o   (hold_fetch),
        .flush_o        (flush)
    );

    fetch_stage #(
        .reset_addr (reset_addr)
    ) fetch_stage_i (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .hold_i      (hold_fetch),
        .redirect_i  (branch_taken),
        .target_i    (branch_target),
        .imem_addr_o (imem_addr_o),
        .imem_req_o  (imem_req_o),
        .pc_o        (f_pc),
        .valid_o     (f_valid)
    );

    decoder decoder_i (
        .instr_i     (if_instr_q),
        .valid_i     (if_valid_q),
        .rs1_o       (dec_rs1),
        .rs2_o       (dec_rs2),
        .rd_o        (dec_rd),
        .imm_o       (dec_imm),
        .alu_op_o    (dec_alu_op),
        .use_imm_o   (dec_use_imm),
        .we_o        (dec_we),
        .is_branch_o (dec_is_branch),
        .branch_ne_o (dec_branch_ne),
        .valid_o     (dec_valid)
    );

    regfile regfile_i (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .we_i     (wb_write),
        .waddr_i  (wb_rd_q),
        .wdata_i  (wb_result_q),
        .raddr1_i (id_rs1_q),
        .raddr2_i (id_rs2_q),
        .rdata1_o (rf_rdata1),
        .rdata2_o (rf_rdata2)
    );

    exe_stage exe_stage_i (
        .pc_i           (rr_pc_q),
        .valid_i        (rr_valid_q),
        .rs1_i          (rr_rs1_q),
        .rs2_i          (rr_rs2_q),
        .op_a_i         (rr_op_a_q),
        .op_b_i         (rr_op_b_q),
        .imm_i          (rr_imm_q),
        .alu_op_i       (rr_alu_op_q),
        .use_imm_i      (rr_use_imm_q),
        .is_branch_i    (rr_is_branch_q),
        .branch_ne_i    (rr_branch_ne_q),
        .wb_we_i        (wb_write),
        .wb_rd_i        (wb_rd_q),
        .wb_data_i      (wb_result_q),
        .result_o       (exe_result),
        .branch_taken_o (branch_taken),
        .target_o       (branch_target)
    );

    // Stage valid bits, a taken branch kills the three younger slots
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            if_valid_q <= 1'b0;
            id_valid_q <= 1'b0;
            rr_valid_q <= 1'b0;
            wb_valid_q <= 1'b0;
        end else begin
            if_valid_q <= f_valid && !flush;
            id_valid_q <= dec_valid && !flush;
            rr_valid_q <= id_valid_q && !flush;
            wb_valid_q <= rr_valid_q;
        end
    end

    // Payload moves every cycle, the pipeline never stalls
    always_ff @(posedge clk_i) begin
        if_pc_q        <= f_pc;
        if_instr_q     <= imem_data_i;

        id_pc_q        <= if_pc_q;
        id_rs1_q       <= dec_rs1;
        id_rs2_q       <= dec_rs2;
        id_rd_q        <= dec_rd;
        id_imm_q       <= dec_imm;
        id_alu_op_q    <= dec_alu_op;
        id_use_imm_q   <= dec_use_imm;
        id_we_q        <= dec_we;
        id_is_branch_q <= dec_is_branch;
        id_branch_ne_q <= dec_branch_ne;

        rr_pc_q        <= id_pc_q;
        rr_rs1_q       <= id_rs1_q;
        rr_rs2_q       <= id_rs2_q;
        rr_rd_q        <= id_rd_q;
        rr_op_a_q      <= rf_rdata1;
        rr_op_b_q      <= rf_rdata2;
        rr_imm_q       <= id_imm_q;
        rr_alu_op_q    <= id_alu_op_q;
        rr_use_imm_q   <= id_use_imm_q;
        rr_we_q        <= id_we_q;
        rr_is_branch_q <= id_is_branch_q;
        rr_branch_ne_q <= id_branch_ne_q;

        wb_pc_q        <= rr_pc_q;
        wb_rd_q        <= rr_rd_q;
        wb_we_q        <= rr_we_q;
        wb_result_q    <= exe_result;
    end

    // Writeback only for a live slot with a real destination
    assign wb_write = wb_valid_q && wb_we_q && (wb_rd_q != '0);

    assign commit_valid_o = wb_valid_q;
    assign commit_pc_o    = wb_pc_q;
    assign commit_we_o    = wb_write;
    assign commit_rd_o    = wb_write ? wb_rd_q : '0;
    assign commit_data_o  = wb_write ? wb_result_q : '0;

endmodule

// File: tb_checker.sv
/*
 * Commit checker
 * Interprets the program on its own register copy, compares every
 * commit in order and checks the fetch request around reset
 */
module tb_checker #(
    parameter logic [31:0] reset_addr = '0,
    parameter int          prog_words = 64
) (
    input  logic        clk_i,
    input  logic        rstn_i,
    input  logic [31:0] prog_i [prog_words],
    input  logic        imem_req_i,
    input  logic [31:0] imem_addr_i,
    input  logic        commit_valid_i,
    input  logic [31:0] commit_pc_i,
    input  logic        commit_we_i,
    input  logic [4:0]  commit_rd_i,
    input  logic [31:0] commit_data_i,
    output logic        done_o,
    output int          err_count_o,
    output int          commit_count_o
);

    localparam logic [31:0] loop_pc = reset_addr + 32'((prog_words - 1) * 4);

    logic [31:0] ref_regs [32];
    logic [31:0] ref_pc;
    logic [31:0] cur_pc;
    logic        exp_we;
    logic [4:0]  exp_rd;
    logic [31:0] exp_data;
    logic        req_seen = 1'b0;
    logic        done = 1'b0;
    int          err_count = 0;
    int          commit_count = 0;

    // One instruction from the RV32I rules, updates the register copy
    function automatic void ref_step(input logic [31:0] pc, output logic we,
                                     output logic [4:0] rd, output logic [31:0] data,
                                     output logic [31:0] next_pc);
        logic [31:0] offset;
        logic [31:0] word;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic        taken;
        offset = pc - reset_addr;
        word    = (offset < 32'(prog_words * 4)) ? prog_i[offset[7:2]] : '0;
        a       = ref_regs[word[19:15]];
        b       = ref_regs[word[24:20]];
        imm     = {{20{word[31]}}, word[31:20]};
        rd      = word[11:7];
        we      = 1'b0;
        data    = '0;
        taken   = 1'b0;
        next_pc = pc + 32'd4;
        case (word[6:0])
            core_pkg::op_reg: begin
                we = 1'b1;
                case (word[14:12])
                    core_pkg::f3_xor: data = a ^ b;
                    core_pkg::f3_or:  data = a | b;
                    core_pkg::f3_and: data = a & b;
                    default:          data = word[30] ? a - b : a + b;
                endcase
            end
            core_pkg::op_imm: begin
                we = 1'b1;
                case (word[14:12])
                    core_pkg::f3_xor: data = a ^ imm;
                    core_pkg::f3_or:  data = a | imm;
                    core_pkg::f3_and: data = a & imm;
                    default:          data = a + imm;
                endcase
            end
            core_pkg::op_lui: begin
                we   = 1'b1;
                data = {word[31:12], 12'b0};
            end
            core_pkg::op_branch: begin
                taken = (word[14:12] == core_pkg::f3_bne) ? (a != b) : (a == b);
                if (taken) begin
                    next_pc = pc + {{19{word[31]}}, word[31], word[7], word[30:25],
                                    word[11:8], 1'b0};
                end
            end
            default: we = 1'b0;
        endcase
        // x0 swallows the write
        if (rd == 5'd0) begin
            we = 1'b0;
        end
        if (we) begin
            ref_regs[rd] = data;
        end
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s: expected %h, got %h", name, exp, got);
            err_count = err_count + 1;
        end
    endtask

    always @(posedge clk_i) begin
        if (!rstn_i) begin
            if (commit_valid_i === 1'b1) begin
                $display("A commit appeared while reset was asserted");
                err_count = err_count + 1;
            end
            if (imem_req_i === 1'b1) begin
                $display("A fetch request appeared while reset was asserted");
                err_count = err_count + 1;
            end
            req_seen = 1'b0;
            ref_pc   = reset_addr;
            for (int r = 0; r < 32; r++) begin
                ref_regs[r] = '0;
            end
        end else begin
            // First request out of reset goes to the reset address
            if (imem_req_i === 1'b1 && !req_seen) begin
                req_seen = 1'b1;
                compare_value("imem_addr_o", imem_addr_i, reset_addr);
            end
            if (commit_valid_i && !done) begin
                cur_pc = ref_pc;
                ref_step(cur_pc, exp_we, exp_rd, exp_data, ref_pc);
                compare_value("commit_pc_o", commit_pc_i, cur_pc);
                compare_value("commit_we_o", 32'(commit_we_i), 32'(exp_we));
                // rd and data only mean something with a write
                if (exp_we) begin
                    compare_value("commit_rd_o", 32'(commit_rd_i), 32'(exp_rd));
                    compare_value("commit_data_o", commit_data_i, exp_data);
                end
                commit_count = commit_count + 1;
                if (cur_pc == loop_pc) begin
                    done = 1'b1;
                end
            end
        end
        done_o         <= done;
        err_count_o    <= err_count;
        commit_count_o <= commit_count;
    end

endmodule

// File: tb_core.sv
/*
 * Testbench for the RV32I core
 * Random program, instruction memory with not-ready cycles and run limit
 */
module tb_core;

    localparam logic [31:0] reset_addr   = 32'h0000_0100;
    localparam int          prog_words   = 64;
    localparam int          reset_cycles = 10;
    localparam int          cycle_limit  = prog_words * 8 + reset_cycles;

    logic        clk_i;
    logic        rstn_i;
    logic [31:0] imem_addr;
    logic        imem_req;
    logic [31:0] imem_data;
    logic        imem_valid;
    logic        commit_valid;
    logic [31:0] commit_pc;
    logic        commit_we;
    logic [4:0]  commit_rd;
    logic [31:0] commit_data;

    logic [31:0] prog [prog_words];
    logic [31:0] fetch_off;
    integer      seed;
    int          cycle_count = 0;
    logic        done;
    int          err_count;
    int          commit_count;

    datapath #(
        .reset_addr (reset_addr)
    ) dut_i (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .imem_addr_o    (imem_addr),
        .imem_req_o     (imem_req),
        .imem_data_i    (imem_data),
        .imem_valid_i   (imem_valid),
        .commit_valid_o (commit_valid),
        .commit_pc_o    (commit_pc),
        .commit_we_o    (commit_we),
        .commit_rd_o    (commit_rd),
        .commit_data_o  (commit_data)
    );

    tb_checker #(
        .reset_addr (reset_addr),
        .prog_words (prog_words)
    ) checker_i (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .prog_i         (prog),
        .imem_req_i     (imem_req),
        .imem_addr_i    (imem_addr),
        .commit_valid_i (commit_valid),
        .commit_pc_i    (commit_pc),
        .commit_we_i    (commit_we),
        .commit_rd_i    (commit_rd),
        .commit_data_i  (commit_data),
        .done_o         (done),
        .err_count_o    (err_count),
        .commit_count_o (commit_count)
    );

    function automatic int unsigned pick(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [31:0] encode_reg(input logic [6:0] f7, input logic [2:0] f3,
                                               input logic [4:0] rd, input logic [4:0] rs1,
                                               input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, core_pkg::op_reg};
    endfunction

    function automatic logic [31:0] encode_imm(input logic [11:0] imm, input logic [2:0] f3,
                                               input logic [4:0] rd, input logic [4:0] rs1);
        return {imm, rs1, f3, rd, core_pkg::op_imm};
    endfunction

    function automatic logic [31:0] encode_lui(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, core_pkg::op_lui};
    endfunction

    // Offset in bytes, bit 0 is dropped by the format
    function automatic logic [31:0] encode_branch(input logic [12:0] off, input logic [2:0] f3,
                                                  input logic [4:0] rs1, input logic [4:0] rs2);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], core_pkg::op_branch};
    endfunction

    // Only x0 to x7 so that results collide and branches get taken
    task automatic build_program();
        int unsigned kind;
        int unsigned sel;
        int unsigned span;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        for (int i = 0; i < prog_words - 1; i++) begin
            kind = pick(8);
            rd   = 5'(pick(8));
            rs1  = 5'(pick(8));
            rs2  = 5'(pick(8));
            if (kind < 3) begin
                sel = pick(5);
                case (sel)
                    2:       f3 = core_pkg::f3_xor;
                    3:       f3 = core_pkg::f3_or;
                    4:       f3 = core_pkg::f3_and;
                    default: f3 = core_pkg::f3_add_sub;
                endcase
                prog[i] = encode_reg((sel == 1) ? core_pkg::f7_sub : 7'b0, f3, rd, rs1, rs2);
            end else if (kind < 5) begin
                sel = pick(4);
                case (sel)
                    1:       f3 = core_pkg::f3_xor;
                    2:       f3 = core_pkg::f3_or;
                    3:       f3 = core_pkg::f3_and;
                    default: f3 = core_pkg::f3_add_sub;
                endcase
                prog[i] = encode_imm(12'(pick(4096)), f3, rd, rs1);
            end else if (kind == 5) begin
                prog[i] = encode_lui(20'(pick(1 << 20)), rd);
            end else begin
                // Forward only, never past the closing loop
                span = 1 + pick((63 - i < 6) ? 63 - i : 6);
                f3   = (pick(2) == 0) ? core_pkg::f3_beq : core_pkg::f3_bne;
                if (f3 == core_pkg::f3_beq && pick(2) == 0) begin
                    rs2 = rs1;
                end
                prog[i] = encode_branch(13'(span * 4), f3, rs1, rs2);
            end
        end
        prog[prog_words - 1] = encode_branch(13'd0, core_pkg::f3_beq, 5'd0, 5'd0);
    endtask

    always #20 clk_i = ~clk_i;

    // Memory answers in the same cycle, past the program it returns zero
    always_comb begin
        fetch_off = imem_addr - reset_addr;
        if (fetch_off < 32'(prog_words * 4)) begin
            imem_data = prog[fetch_off[7:2]];
        end else begin
            imem_data = '0;
        end
    end

    // Roughly one cycle in four is not ready
    always @(posedge clk_i) begin
        imem_valid <= (pick(4) != 0);
    end

    initial begin
        seed       = 12;
        clk_i      = 1'b0;
        rstn_i     = 1'b0;
        imem_valid = 1'b0;
        build_program();
        repeat (reset_cycles) @(posedge clk_i);
        rstn_i <= 1'b1;
    end

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (done) begin
            $display("tb_core: %0d commits checked, %0d errors", commit_count, err_count);
            if (err_count == 0) begin
                $display(">>> PASS");
            end else begin
                $display(">>> FAIL");
            end
            $finish;
        end else if (cycle_count >= cycle_limit) begin
            $display("Timeout: the closing loop did not commit within %0d cycles", cycle_limit);
            $display("tb_core: %0d commits checked, %0d errors", commit_count, err_count);
            $display(">>> FAIL");
            $finish;
        end
    end

endmodule

// File: sources.f
core_pkg.sv
fetch_stage.sv
decoder.sv
regfile.sv
exe_stage.sv
control_unit.sv
datapath.sv
tb_checker.sv
tb_core.sv

// File: Makefile
VERILATOR  ?= verilator
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing
TOP        := tb_core
FILELIST   := sources.f
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
